// ==== compile.f ====
mem_pkg.sv
dmem_bank.sv
mem_access.sv
wb_stage.sv
io_regs.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== dmem_bank.sv ====
`timescale 1ns/100ps

module dmem_bank #(
    parameter int ADDR_W = 14
) (
    input  logic              clk,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic              we_i,
    input  logic [7:0]        wdata_i,
    output logic [7:0]        rdata_o
);

    // One byte lane whose contents survive reset
    logic [7:0] mem [2**ADDR_W];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i]; // Asynchronous read

endmodule

// ==== io_regs.sv ====
`timescale 1ns/100ps

module io_regs import mem_pkg::*; #(
    parameter int IO_WAIT = 3
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic [XLEN-1:0] b_addr_i,
    input  logic [XLEN-1:0] b_wdata_i,
    input  logic            b_read_i,
    input  logic            b_write_i,
    output logic [XLEN-1:0] b_rdata_o,
    output logic            b_ack_o
);

    localparam int CNT_W = $clog2(IO_WAIT + 1);

    logic [XLEN-1:0]         regs [2**IO_REG_SEL_W];
    logic [IO_REG_SEL_W-1:0] sel;
    logic [CNT_W-1:0]        wait_cnt;
    logic                    req;
    logic                    ack_q;

    assign sel = b_addr_i[IO_REG_SEL_W+1:2];
    assign req = b_read_i | b_write_i;

    // Ack lands IO_WAIT cycles after the request starts
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wait_cnt <= '0;
            ack_q    <= 1'b0;
        end else begin
            ack_q    <= req && !ack_q && (wait_cnt == CNT_W'(IO_WAIT - 1));
            wait_cnt <= (!req || ack_q) ? '0 : wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**IO_REG_SEL_W; i++) begin
                regs[i] <= '0;
            end
        end else if (ack_q && b_write_i) begin
            regs[sel] <= b_wdata_i; // Write on the ack cycle
        end
    end

    assign b_ack_o   = ack_q;
    assign b_rdata_o = regs[sel];

    // Master must still hold its request when the ack arrives
    a_ack_in_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        b_ack_o |-> req);

endmodule

// ==== mem_access.sv ====
`timescale 1ns/100ps

module mem_access import mem_pkg::*; #(
    parameter int ADDR_W = 14
) (
    input  logic            clk,
    input  logic            rst_n_i,

    // Operation from EX/MEM
    input  logic            m_valid_i,
    input  logic            m_mem_read_i,
    input  logic            m_mem_write_i,
    input  logic            m_jal_i,
    input  logic            m_lui_i,
    input  mem_mask_t       m_mem_type_i,
    input  logic [XLEN-1:0] m_alu_out_i,  // Address or ALU result
    input  logic [XLEN-1:0] m_mem_data_i,
    input  logic            m_fwd_i,
    input  logic [XLEN-1:0] m_imm_i,
    input  logic [XLEN-1:0] m_pc_inc_i,
    input  logic [RD_W-1:0] m_rd_i,
    input  logic [XLEN-1:0] last_wb_data_i, // Forwarded write-back value

    // IO bus
    output logic [XLEN-1:0] b_addr_o,
    output logic [XLEN-1:0] b_wdata_o,
    output logic            b_read_o,
    output logic            b_write_o,
    input  logic [XLEN-1:0] b_rdata_i,
    input  logic            b_ack_i,

    // To writeback
    output logic            stall_o,
    output logic            accept_o,
    output logic [XLEN-1:0] read_data_o,
    output logic [XLEN-1:0] reg_data_o
);

    logic              io_sel;
    logic [XLEN-1:0]   write_data;
    logic [ADDR_W-1:0] bank_addr;
    logic [LANES-1:0]  lane_en;
    logic [XLEN-1:0]   lane_data;
    logic [XLEN-1:0]   mem_word;
    logic              mem_we;

    assign io_sel     = (m_alu_out_i[XLEN-1 -: IO_TAG_W] == IO_MEM_SPACE);
    assign write_data = m_fwd_i ? last_wb_data_i : m_mem_data_i;
    assign bank_addr  = m_alu_out_i[ADDR_W+1:2];

    // Lane enables and replicated store data
    always_comb begin
        lane_en   = '0;
        lane_data = write_data;
        unique case (m_mem_type_i)
            MEM_BYTE: begin
                lane_en   = 4'b0001 << m_alu_out_i[1:0];
                lane_data = {LANES{write_data[7:0]}};
            end
            MEM_HALF: begin
                lane_en   = m_alu_out_i[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{write_data[15:0]}};
            end
            MEM_WORD: lane_en = 4'b1111;
            default: lane_en = '0; // Unsigned types are loads only
        endcase
    end

    // Banks only see accepted stores outside the IO region
    assign mem_we = accept_o & m_mem_write_i & ~io_sel;

    for (genvar i = 0; i < LANES; i++) begin : g_bank
        dmem_bank #(
            .ADDR_W (ADDR_W)
        ) dmem_bank_i (
            .clk     (clk),
            .addr_i  (bank_addr),
            .we_i    (mem_we & lane_en[i]),
            .wdata_i (lane_data[8*i +: 8]),
            .rdata_o (mem_word[8*i +: 8])
        );
    end

    // Bus request held by the source until ack
    assign b_addr_o  = m_alu_out_i;
    assign b_wdata_o = write_data;
    assign b_read_o  = m_valid_i & io_sel & m_mem_read_i;
    assign b_write_o = m_valid_i & io_sel & m_mem_write_i;
    assign stall_o   = (b_read_o | b_write_o) & ~b_ack_i;

    assign accept_o    = m_valid_i & ~stall_o;
    assign read_data_o = io_sel ? b_rdata_i : mem_word;
    assign reg_data_o  = m_jal_i ? m_pc_inc_i : (m_lui_i ? m_imm_i : m_alu_out_i);

    a_half_align: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_valid_i && (m_mem_read_i || m_mem_write_i) &&
        (m_mem_type_i inside {MEM_HALF, MEM_UHALF}) |-> !m_alu_out_i[0]);

    a_word_align: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_valid_i && (m_mem_read_i || m_mem_write_i) && (m_mem_type_i == MEM_WORD)
        |-> (m_alu_out_i[1:0] == 2'b00));

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_valid_i |-> !(m_mem_read_i && m_mem_write_i));

    // Source keeps the stalled operation steady until the ack
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_o |=> m_valid_i && $stable(m_alu_out_i) && $stable(m_mem_type_i) &&
        $stable(m_mem_read_i) && $stable(m_mem_write_i) && $stable(m_rd_i));

endmodule

// ==== mem_pkg.sv ====
package mem_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Destination register index width
    localparam int RD_W = 5;

    // Address top bits that select the IO bus
    localparam int IO_TAG_W = 24;
    localparam logic [IO_TAG_W-1:0] IO_MEM_SPACE = 24'h000000;

    // Address bits 3:2 pick one of the io_regs registers
    localparam int IO_REG_SEL_W = 2;

    // Number of byte lanes in a word
    localparam int LANES = XLEN / 8;

    // Access size and extension of a load or store
    typedef enum logic [2:0] {
        MEM_BYTE  = 3'd0, // SB, LB
        MEM_HALF  = 3'd1, // SH, LH
        MEM_WORD  = 3'd2, // SW, LW
        MEM_UBYTE = 3'd3, // LBU only
        MEM_UHALF = 3'd4  // LHU only
    } mem_mask_t;

endpackage

// ==== mem_subsys_top.sv ====
`timescale 1ns/100ps

module mem_subsys_top import mem_pkg::*; #(
    parameter int ADDR_W  = 14,
    parameter int IO_WAIT = 3
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            m_valid_i,
    input  logic            m_mem_read_i,
    input  logic            m_mem_write_i,
    input  logic            m_jal_i,
    input  logic            m_lui_i,
    input  mem_mask_t       m_mem_type_i,
    input  logic [XLEN-1:0] m_alu_out_i,
    input  logic [XLEN-1:0] m_mem_data_i,
    input  logic            m_fwd_i,
    input  logic [XLEN-1:0] m_imm_i,
    input  logic [XLEN-1:0] m_pc_inc_i,
    input  logic [RD_W-1:0] m_rd_i,
    output logic            stall_o,
    output logic            b_read_o,
    output logic            b_write_o,
    output logic            wb_valid_o,
    output logic [RD_W-1:0] wb_rd_o,
    output logic [XLEN-1:0] wb_data_o
);

    logic [XLEN-1:0] b_addr;
    logic [XLEN-1:0] b_wdata;
    logic [XLEN-1:0] b_rdata;
    logic            b_ack;
    logic            accept;
    logic [XLEN-1:0] read_data;
    logic [XLEN-1:0] reg_data;

    mem_access #(
        .ADDR_W (ADDR_W)
    ) mem_access_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .m_valid_i      (m_valid_i),
        .m_mem_read_i   (m_mem_read_i),
        .m_mem_write_i  (m_mem_write_i),
        .m_jal_i        (m_jal_i),
        .m_lui_i        (m_lui_i),
        .m_mem_type_i   (m_mem_type_i),
        .m_alu_out_i    (m_alu_out_i),
        .m_mem_data_i   (m_mem_data_i),
        .m_fwd_i        (m_fwd_i),
        .m_imm_i        (m_imm_i),
        .m_pc_inc_i     (m_pc_inc_i),
        .m_rd_i         (m_rd_i),
        .last_wb_data_i (wb_data_o), // Forwarding path
        .b_addr_o       (b_addr),
        .b_wdata_o      (b_wdata),
        .b_read_o       (b_read_o),
        .b_write_o      (b_write_o),
        .b_rdata_i      (b_rdata),
        .b_ack_i        (b_ack),
        .stall_o        (stall_o),
        .accept_o       (accept),
        .read_data_o    (read_data),
        .reg_data_o     (reg_data)
    );

    io_regs #(
        .IO_WAIT (IO_WAIT)
    ) io_regs_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .b_addr_i  (b_addr),
        .b_wdata_i (b_wdata),
        .b_read_i  (b_read_o),
        .b_write_i (b_write_o),
        .b_rdata_o (b_rdata),
        .b_ack_o   (b_ack)
    );

    wb_stage wb_stage_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .accept_i    (accept),
        .mem_read_i  (m_mem_read_i),
        .mem_type_i  (m_mem_type_i),
        .addr_lo_i   (m_alu_out_i[1:0]),
        .read_data_i (read_data),
        .reg_data_i  (reg_data),
        .rd_i        (m_rd_i),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_mem_subsys -f compile.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== tb_mem_subsys.sv ====
`timescale 1ns/100ps

module tb_mem_subsys import mem_pkg::*; ();

    localparam int IO_WAIT    = 3;
    localparam int N_DIRECTED = 200; // Upper bound of the directed sequence
    localparam int N_RANDOM   = 300;
    localparam int WATCHDOG_CYCLES = 2000 + (IO_WAIT + 2) * (N_DIRECTED + N_RANDOM);

    logic            clk = 1'b0;
    logic            rst_n_i;
    logic            m_valid_i;
    logic            m_mem_read_i;
    logic            m_mem_write_i;
    logic            m_jal_i;
    logic            m_lui_i;
    mem_mask_t       m_mem_type_i;
    logic [XLEN-1:0] m_alu_out_i;
    logic [XLEN-1:0] m_mem_data_i;
    logic            m_fwd_i;
    logic [XLEN-1:0] m_imm_i;
    logic [XLEN-1:0] m_pc_inc_i;
    logic [RD_W-1:0] m_rd_i;
    logic            stall_o;
    logic            b_read_o;
    logic            b_write_o;
    logic            wb_valid_o;
    logic [RD_W-1:0] wb_rd_o;
    logic [XLEN-1:0] wb_data_o;

    logic [7:0]  mem_model [65536];
    logic [31:0] io_model [2**IO_REG_SEL_W];
    logic [36:0] exp_q [$]; // {rd, data} per accepted operation
    logic [36:0] exp_head;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic [31:0] last_wb;
    logic        accepted;    // Operation accepted in this cycle
    logic        exp_stall;
    logic        exp_bread;
    logic        exp_bwrite;
    logic        rst_settled;

    mem_subsys_top dut_i (.*);

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Error %s: got 0x%0h, expected 0x%0h", name, got, exp);
        abort_run();
    endtask

    a_reset_quiet: assert property (@(posedge clk) !rst_n_i && rst_settled |->
        !wb_valid_o && !stall_o && !b_read_o && !b_write_o)
        else report_mismatch("{wb_valid_o, stall_o, b_read_o, b_write_o} in reset",
            32'({$sampled(wb_valid_o), $sampled(stall_o), $sampled(b_read_o),
                 $sampled(b_write_o)}), 32'h0);
    a_wb_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        accepted |=> wb_valid_o)
        else report_mismatch("wb_valid_o", 32'($sampled(wb_valid_o)), 32'h1);
    a_wb_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        !accepted |=> !wb_valid_o)
        else report_mismatch("wb_valid_o", 32'($sampled(wb_valid_o)), 32'h0);
    a_wb_data: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o |-> wb_data_o == exp_data)
        else report_mismatch("wb_data_o", $sampled(wb_data_o), $sampled(exp_data));
    a_wb_rd: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_valid_o |-> wb_rd_o == exp_rd)
        else report_mismatch("wb_rd_o", 32'($sampled(wb_rd_o)), 32'($sampled(exp_rd)));
    a_stall: assert property (@(posedge clk) disable iff (!rst_n_i) stall_o == exp_stall)
        else report_mismatch("stall_o", 32'($sampled(stall_o)), 32'($sampled(exp_stall)));
    a_bus_read: assert property (@(posedge clk) disable iff (!rst_n_i) b_read_o == exp_bread)
        else report_mismatch("b_read_o", 32'($sampled(b_read_o)), 32'($sampled(exp_bread)));
    a_bus_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        b_write_o == exp_bwrite)
        else report_mismatch("b_write_o", 32'($sampled(b_write_o)),
            32'($sampled(exp_bwrite)));

    // Result of the operation accepted in the cycle that just ended
    always @(posedge clk) begin
        if (rst_n_i && accepted) begin
            if (exp_q.size() == 0) begin
                $display("An operation was accepted but no expected result was queued");
                abort_run();
            end else begin
                exp_head = exp_q.pop_front();
                exp_rd   <= exp_head[36:32];
                exp_data <= exp_head[31:0];
            end
        end
    end

    function automatic logic [31:0] load_value(input mem_mask_t t, input logic [15:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = mem_model[a];
        h = {mem_model[a + 16'd1], mem_model[a]};
        case (t)
            MEM_BYTE:  return {{24{b[7]}}, b};
            MEM_UBYTE: return {24'h0, b};
            MEM_HALF:  return {{16{h[15]}}, h};
            MEM_UHALF: return {16'h0, h};
            default:   return {mem_model[a + 16'd3], mem_model[a + 16'd2], h};
        endcase
    endfunction

    // Reference model update at the start of the accept cycle
    function automatic void model_accept(input logic rd_en, input logic wr_en,
        input logic jal, input logic lui, input mem_mask_t t, input logic [31:0] addr,
        input logic [31:0] data, input logic fwd, input logic [31:0] imm,
        input logic [31:0] pc_inc, input logic [4:0] rd, input logic io);
        logic [31:0] wdata;
        logic [31:0] result;
        logic [15:0] a;
        wdata = fwd ? last_wb : data;
        a = addr[15:0]; // Banks hold 64 KB
        if (rd_en) begin
            result = io ? io_model[addr[IO_REG_SEL_W+1:2]] : load_value(t, a);
        end else begin
            result = jal ? pc_inc : (lui ? imm : addr);
        end
        if (wr_en && io) begin
            io_model[addr[IO_REG_SEL_W+1:2]] = wdata;
        end else if (wr_en) begin
            if (t inside {MEM_BYTE, MEM_HALF, MEM_WORD}) mem_model[a] = wdata[7:0];
            if (t inside {MEM_HALF, MEM_WORD}) mem_model[a + 16'd1] = wdata[15:8];
            if (t == MEM_WORD) begin
                mem_model[a + 16'd2] = wdata[23:16];
                mem_model[a + 16'd3] = wdata[31:24];
            end
        end
        exp_q.push_back({rd, result});
        last_wb = result;
    endfunction

    task automatic issue_op(input logic rd_en, input logic wr_en, input logic jal,
        input logic lui, input mem_mask_t t, input logic [31:0] addr,
        input logic [31:0] data, input logic fwd);
        logic [31:0] imm;
        logic [31:0] pc_inc;
        logic [4:0]  rd;
        logic        io;
        int          waits;
        imm    = $urandom;
        pc_inc = $urandom;
        rd     = 5'($urandom);
        io     = (addr[31:8] == IO_MEM_SPACE) && (rd_en || wr_en);
        waits  = io ? IO_WAIT : 0;
        @(posedge clk);
        m_valid_i     <= 1'b1;
        m_mem_read_i  <= rd_en;
        m_mem_write_i <= wr_en;
        m_jal_i       <= jal;
        m_lui_i       <= lui;
        m_mem_type_i  <= t;
        m_alu_out_i   <= addr;
        m_mem_data_i  <= data;
        m_fwd_i       <= fwd;
        m_imm_i       <= imm;
        m_pc_inc_i    <= pc_inc;
        m_rd_i        <= rd;
        exp_bread     <= io && rd_en;
        exp_bwrite    <= io && wr_en;
        for (int i = 0; i < waits; i++) begin // Inputs held through the IO wait states
            exp_stall <= 1'b1;
            accepted  <= 1'b0;
            @(posedge clk);
        end
        exp_stall <= 1'b0;
        accepted  <= 1'b1;
        model_accept(rd_en, wr_en, jal, lui, t, addr, data, fwd, imm, pc_inc, rd, io);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        m_valid_i     <= 1'b0;
        m_mem_read_i  <= 1'b0;
        m_mem_write_i <= 1'b0;
        exp_stall     <= 1'b0;
        exp_bread     <= 1'b0;
        exp_bwrite    <= 1'b0;
        accepted      <= 1'b0;
    endtask

    task automatic store_op(input mem_mask_t t, input logic [31:0] a,
                            input logic [31:0] d, input logic fwd);
        issue_op(1'b0, 1'b1, 1'b0, 1'b0, t, a, d, fwd);
    endtask

    task automatic load_op(input mem_mask_t t, input logic [31:0] a);
        issue_op(1'b1, 1'b0, 1'b0, 1'b0, t, a, $urandom, 1'b0);
    endtask

    function automatic logic [31:0] align_addr(input mem_mask_t t, input logic [31:0] a);
        if (t == MEM_WORD) return {a[31:2], 2'b00};
        if (t inside {MEM_HALF, MEM_UHALF}) return {a[31:1], 1'b0};
        return a;
    endfunction

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        mem_mask_t   t;
        void'($urandom(82));
        rst_n_i = 1'b0;
        m_valid_i = 1'b0;
        m_mem_read_i = 1'b0;
        m_mem_write_i = 1'b0;
        m_jal_i = 1'b0;
        m_lui_i = 1'b0;
        m_mem_type_i = MEM_WORD;
        m_alu_out_i = '0;
        m_mem_data_i = '0;
        m_fwd_i = 1'b0;
        m_imm_i = '0;
        m_pc_inc_i = '0;
        m_rd_i = '0;
        accepted = 1'b0;
        exp_stall = 1'b0;
        exp_bread = 1'b0;
        exp_bwrite = 1'b0;
        rst_settled = 1'b0;
        last_wb = '0;
        for (int i = 0; i < 65536; i++) mem_model[i] = 8'h00;
        for (int i = 0; i < 4; i++) io_model[i] = 32'h0;
        @(posedge clk);
        rst_settled <= 1'b1;
        repeat (15) @(posedge clk);
        rst_n_i <= 1'b1;

        // Word round trip over the whole window plus a word that aliases IO register 1
        store_op(MEM_WORD, 32'h0001_0004, $urandom, 1'b0);
        for (int i = 0; i < 64; i++) store_op(MEM_WORD, 32'h100 + 4 * i, $urandom, 1'b0);
        for (int i = 0; i < 64; i++) load_op(MEM_WORD, 32'h100 + 4 * i);

        // Sub-word lanes with negative bytes first
        store_op(MEM_WORD, 32'h120, 32'h0, 1'b0);
        for (int i = 0; i < 4; i++) store_op(MEM_BYTE, 32'h120 + i, 32'h80 + 33 * i, 1'b0);
        load_op(MEM_WORD, 32'h120);
        for (int i = 0; i < 4; i++) begin
            load_op(MEM_BYTE, 32'h120 + i);
            load_op(MEM_UBYTE, 32'h120 + i);
        end
        store_op(MEM_HALF, 32'h120, 32'h0000_7FFE, 1'b0);
        store_op(MEM_HALF, 32'h122, 32'h0000_8001, 1'b0);
        load_op(MEM_WORD, 32'h120);
        for (int i = 0; i < 4; i += 2) begin
            load_op(MEM_HALF, 32'h120 + i);
            load_op(MEM_UHALF, 32'h120 + i);
        end
        for (int i = 0; i < 4; i++) begin
            load_op(MEM_BYTE, 32'h120 + i);
            load_op(MEM_UBYTE, 32'h120 + i);
        end

        issue_op(1'b0, 1'b0, 1'b1, 1'b0, MEM_WORD, $urandom, $urandom, 1'b0); // JAL
        issue_op(1'b0, 1'b0, 1'b0, 1'b1, MEM_WORD, $urandom, $urandom, 1'b0); // LUI
        issue_op(1'b0, 1'b0, 1'b0, 1'b0, MEM_WORD, $urandom, $urandom, 1'b0);

        // IO register writes followed by reads through aliased offsets
        for (int i = 0; i < 4; i++) store_op(MEM_WORD, 4 * i, $urandom, 1'b0);
        for (int i = 0; i < 4; i++) load_op(MEM_WORD, 32'h10 + 4 * i);
        load_op(MEM_WORD, 32'h0001_0004);

        // Forwarded store data
        issue_op(1'b0, 1'b0, 1'b0, 1'b0, MEM_WORD, 32'hCAFE_F00D, $urandom, 1'b0);
        store_op(MEM_WORD, 32'h140, $urandom, 1'b1);
        load_op(MEM_WORD, 32'h140);
        store_op(MEM_BYTE, 32'h143, $urandom, 1'b1);
        load_op(MEM_WORD, 32'h140);

        for (int n = 0; n < N_RANDOM; n++) begin
            a = 32'h100 + $urandom_range(255);
            d = $urandom;
            case ($urandom_range(7))
                0, 1, 2: begin
                    t = mem_mask_t'(3'($urandom_range(2)));
                    store_op(t, align_addr(t, a), d, $urandom_range(3) == 0);
                end
                3, 4, 5: begin
                    t = mem_mask_t'(3'($urandom_range(4)));
                    load_op(t, align_addr(t, a));
                end
                6: issue_op(1'b0, 1'b0, 1'($urandom), 1'($urandom), MEM_WORD, d, $urandom, 1'b0);
                default: begin
                    a = {24'h0, 8'($urandom_range(255)) & 8'hFC}; // IO region
                    if ($urandom_range(1) == 0) store_op(MEM_WORD, a, d, $urandom_range(3) == 0);
                    else load_op(MEM_WORD, a);
                end
            endcase
            if ($urandom_range(7) == 0) idle_cycle();
        end
        idle_cycle();
        repeat (4) @(posedge clk);
        if (exp_q.size() != 0) begin
            $display("%0d expected results were never written back", exp_q.size());
            abort_run();
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles, test sequence did not finish", WATCHDOG_CYCLES);
        abort_run();
    end

endmodule

// ==== wb_stage.sv ====
`timescale 1ns/100ps

module wb_stage import mem_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            accept_i,
    input  logic            mem_read_i,
    input  mem_mask_t       mem_type_i,
    input  logic [1:0]      addr_lo_i,
    input  logic [XLEN-1:0] read_data_i,
    input  logic [XLEN-1:0] reg_data_i,
    input  logic [RD_W-1:0] rd_i,
    output logic            wb_valid_o,
    output logic [RD_W-1:0] wb_rd_o,
    output logic [XLEN-1:0] wb_data_o
);

    logic            valid_q;
    logic            mem_read_q;
    mem_mask_t       mem_type_q;
    logic [1:0]      addr_lo_q;
    logic [XLEN-1:0] read_data_q;
    logic [XLEN-1:0] reg_data_q;
    logic [RD_W-1:0] rd_q;
    logic [7:0]      ld_byte;
    logic [15:0]     ld_half;
    logic [XLEN-1:0] load_val;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= accept_i;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        if (accept_i) begin
            mem_read_q  <= mem_read_i;
            mem_type_q  <= mem_type_i;
            addr_lo_q   <= addr_lo_i;
            read_data_q <= read_data_i;
            reg_data_q  <= reg_data_i;
            rd_q        <= rd_i;
        end
    end

    assign ld_byte = read_data_q[{addr_lo_q, 3'b000} +: 8];
    assign ld_half = addr_lo_q[1] ? read_data_q[31:16] : read_data_q[15:0];

    // Load alignment and extension
    always_comb begin
        unique case (mem_type_q)
            MEM_BYTE:  load_val = {{(XLEN-8){ld_byte[7]}}, ld_byte};
            MEM_UBYTE: load_val = {{(XLEN-8){1'b0}}, ld_byte};
            MEM_HALF:  load_val = {{(XLEN-16){ld_half[15]}}, ld_half};
            MEM_UHALF: load_val = {{(XLEN-16){1'b0}}, ld_half};
            default:   load_val = read_data_q;
        endcase
    end

    assign wb_valid_o = valid_q;
    assign wb_rd_o    = rd_q;
    assign wb_data_o  = mem_read_q ? load_val : reg_data_q;

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown(wb_valid_o));

endmodule
